//--- rtl/pcm_decoder_pkg.sv
// register map, control field positions, decode mode codes, derandomizer constants
package pcm_decoder_pkg;

  // ------------------------------
  // register bus
  // ------------------------------

  localparam int ADDR_WIDTH = 13;
  localparam int BUS_WIDTH  = 16;
  // one write strobe per byte lane
  localparam int LANE_WIDTH = 8;

  // decoder control register
  localparam logic [ADDR_WIDTH-1:0] DEC_CTRL_ADDR = 13'h0100;
  // implemented bits, 15:13 read as zero
  localparam int CTRL_WIDTH = 13;

  // ------------------------------
  // control field positions
  // ------------------------------

  localparam int FLD_FIFO_RS     = 0;
  localparam int FLD_CLK_INV     = 1;
  localparam int FLD_CLK_SEL     = 2;
  localparam int FLD_DATA_INV    = 3;
  localparam int FLD_DERAND      = 4;
  localparam int FLD_DEMUX       = 5;
  localparam int FLD_FEHER       = 6;
  localparam int FLD_SWAP        = 7;
  localparam int FLD_BIPHASE     = 8;
  // sign/magnitude soft output, reserved
  localparam int FLD_SIGN_MAG    = 9;
  // low bit of the two-bit decode mode
  localparam int FLD_MODE_LO     = 10;
  localparam int MODE_WIDTH      = 2;
  localparam int FLD_BYPASS_FIFO = 12;

  // decode modes, code 3 acts as nrz-l
  localparam logic [MODE_WIDTH-1:0] MODE_NRZL = 2'd0;
  localparam logic [MODE_WIDTH-1:0] MODE_NRZM = 2'd1;
  localparam logic [MODE_WIDTH-1:0] MODE_NRZS = 2'd2;

  // ------------------------------
  // derandomizer
  // ------------------------------

  // 15-stage self-synchronizing register
  localparam int DERAND_LEN   = 15;
  // feedback taps, 15 and 14 bits back
  localparam int DERAND_TAP_A = 14;
  localparam int DERAND_TAP_B = 13;

endpackage

//--- rtl/biphase_to_nrz.sv
// biphase-l chip pairing into nrz bits on the i rail, bit strobe generation
`timescale 1ns/1ps

module biphase_to_nrz
(
  input  logic clk,
  input  logic rs,
  input  logic symb_clk_en_i,
  input  logic biphase_i,
  input  logic symb_i,
  output logic nrz_o,
  output logic bit_en_o
);

  // high while the second chip of a pair is expected
  logic phase_q;
  // first chip of the current pair
  logic chip_q;
  logic nrz_q;

  // pairing starts fresh from reset and whenever biphase is off
  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      phase_q <= 1'b0;
    end
    else if (!biphase_i)
    begin
      phase_q <= 1'b0;
    end
    else if (symb_clk_en_i)
    begin
      phase_q <= ~phase_q;
    end
  end

  // chips 1,0 decode to 1 and 0,1 to 0, so the first chip is the bit
  always_ff @(posedge clk)
  begin
    if (symb_clk_en_i)
    begin
      if (!biphase_i)
      begin
        nrz_q <= symb_i;
      end
      else if (phase_q)
      begin
        nrz_q <= chip_q;
      end
      else
      begin
        chip_q <= symb_i;
      end
    end
  end

  assign nrz_o = nrz_q;

  // one strobe per pair in biphase mode, otherwise every symbol strobe qualifies
  assign bit_en_o = biphase_i ? (symb_clk_en_i & phase_q) : 1'b1;

endmodule

//--- rtl/mark_space_decoder.sv
// nrz-l, nrz-m and nrz-s differential decoding of one rail
`timescale 1ns/1ps

module mark_space_decoder
  import pcm_decoder_pkg::*;
(
  input  logic                  clk,
  input  logic                  rs,
  input  logic                  clk_en_i,
  input  logic                  bit_en_i,
  input  logic [MODE_WIDTH-1:0] mode_i,
  input  logic                  din_i,
  input  logic                  last_din_i,
  output logic                  dout_o
);

  // level change between consecutive bits
  logic change;
  logic dec_d;
  logic dec_q;

  assign change = din_i ^ last_din_i;

  always_comb
  begin
    case (mode_i)
      // mark, a transition is a one
      MODE_NRZM: dec_d = change;
      // space, no transition is a one
      MODE_NRZS: dec_d = ~change;
      // nrz-l and the spare code pass straight through
      MODE_NRZL: dec_d = din_i;
      default:   dec_d = din_i;
    endcase
  end

  // one result per decoded bit
  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      dec_q <= 1'b0;
    end
    else if (clk_en_i && bit_en_i)
    begin
      dec_q <= dec_d;
    end
  end

  assign dout_o = dec_q;

endmodule

//--- rtl/iq_demux.sv
// qpsk/oqpsk and fqpsk demultiplexing with registered output selection
`timescale 1ns/1ps

module iq_demux
(
  input  logic clk,
  input  logic symb_clk_en_i,
  input  logic symb_clk_2x_en_i,
  input  logic swap_i,
  input  logic demux_i,
  input  logic feher_i,
  input  logic dec_i_i,
  input  logic dec_q_i,
  output logic sel_i_o,
  output logic sel_q_o
);

  // set on the half-symbol strobe that lines up with the symbol strobe
  logic phase_q;
  // rail pick for this half symbol
  logic pick;
  logic demux_q;
  // i from the previous half symbol, for fqpsk
  logic dec_dly_i_q;
  logic feher_q;
  // value sent out in single rail modes
  logic chosen;
  logic sel_i_q;
  logic sel_q_q;

  assign pick = swap_i ^ phase_q;

  // ------------------------------
  // half-symbol phase and demux
  // ------------------------------

  always_ff @(posedge clk)
  begin
    if (symb_clk_2x_en_i)
    begin
      phase_q <= symb_clk_en_i;
      // qpsk alternates i and q bits onto one rail
      demux_q <= pick ? dec_i_i : dec_q_i;
      // fqpsk differential pairing with the delayed i bit
      dec_dly_i_q <= dec_i_i;
      feher_q <= pick ? (dec_dly_i_q ^ dec_q_i) : (dec_dly_i_q ^ ~dec_q_i);
    end
  end

  // ------------------------------
  // output selection
  // ------------------------------

  // fqpsk wins over plain demux
  assign chosen = feher_i ? feher_q : demux_q;

  always_ff @(posedge clk)
  begin
    if (symb_clk_2x_en_i)
    begin
      if (feher_i || demux_i)
      begin
        // single rail, i carries the complement
        sel_i_q <= ~chosen;
        sel_q_q <= chosen;
      end
      else
      begin
        sel_i_q <= dec_i_i;
        sel_q_q <= dec_q_i;
      end
    end
  end

  assign sel_i_o = sel_i_q;
  assign sel_q_o = sel_q_q;

endmodule

//--- rtl/nrz_derandomizer.sv
// 15-stage self-synchronizing derandomizer for randomized nrz-l, with bypass
`timescale 1ns/1ps

module nrz_derandomizer
  import pcm_decoder_pkg::*;
(
  input  logic clk,
  input  logic rs,
  input  logic shift_en_i,
  input  logic bypass_n_i,
  input  logic din_i,
  output logic dout_o
);

  // received bits, newest in bit 0
  logic [DERAND_LEN-1:0] shift_q;
  logic                  derand_q;

  // self-synchronizing, the register holds channel bits only
  // so any bit error flushes out after DERAND_LEN bits
  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      shift_q  <= '0;
      derand_q <= 1'b0;
    end
    else if (shift_en_i)
    begin
      shift_q  <= {shift_q[DERAND_LEN-2:0], din_i};
      // undo the 1 + x^14 + x^15 scrambler
      derand_q <= din_i ^ shift_q[DERAND_TAP_A] ^ shift_q[DERAND_TAP_B];
    end
  end

  // low bypass_n passes the channel bits through
  assign dout_o = bypass_n_i ? derand_q : din_i;

endmodule

//--- rtl/decoder_regs.sv
// decoder control register with byte-lane writes and address-decoded read-back
`timescale 1ns/1ps

module decoder_regs
  import pcm_decoder_pkg::*;
(
  input  logic                  clk,
  input  logic                  rs,
  input  logic                  en_i,
  input  logic                  wr0_i,
  input  logic                  wr1_i,
  input  logic [ADDR_WIDTH-1:0] addr_i,
  input  logic [BUS_WIDTH-1:0]  din_i,
  output logic [BUS_WIDTH-1:0]  dout_o,
  output logic [CTRL_WIDTH-1:0] ctrl_o
);

  // access to this register
  logic                  hit;
  logic [CTRL_WIDTH-1:0] ctrl_q;

  assign hit = en_i && (addr_i == DEC_CTRL_ADDR);

  // ------------------------------
  // byte-lane writes
  // ------------------------------

  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      ctrl_q <= '0;
    end
    else if (hit)
    begin
      // low lane, bits 7:0
      if (wr0_i)
      begin
        ctrl_q[LANE_WIDTH-1:0] <= din_i[LANE_WIDTH-1:0];
      end
      // high lane, only 12:8 exist
      if (wr1_i)
      begin
        ctrl_q[CTRL_WIDTH-1:LANE_WIDTH] <= din_i[CTRL_WIDTH-1:LANE_WIDTH];
      end
    end
  end

  // ------------------------------
  // read-back
  // ------------------------------

  // zero-extended while addressed, zero otherwise
  assign dout_o = hit ? BUS_WIDTH'(ctrl_q) : '0;

  assign ctrl_o = ctrl_q;

endmodule

//--- rtl/pcm_decoder.sv
// pcm bit decoder top with i/q resync delay, data inversion and output strobes
`timescale 1ns/1ps

module pcm_decoder
  import pcm_decoder_pkg::*;
(
  input  logic                  clk,
  input  logic                  rs,
  input  logic                  en_i,
  input  logic                  wr0_i,
  input  logic                  wr1_i,
  input  logic [ADDR_WIDTH-1:0] addr_i,
  input  logic [BUS_WIDTH-1:0]  din_i,
  input  logic                  symb_clk_en_i,
  input  logic                  symb_clk_2x_en_i,
  input  logic                  symb_i_i,
  input  logic                  symb_q_i,
  output logic [BUS_WIDTH-1:0]  dout_o,
  output logic                  data_i_o,
  output logic                  data_q_o,
  output logic                  cout_o,
  output logic                  symb_clk_o,
  output logic                  fifo_rs_o,
  output logic                  clk_inv_o,
  output logic                  bypass_fifo_o
);

  logic [CTRL_WIDTH-1:0] ctrl;
  logic [MODE_WIDTH-1:0] mode;
  logic clk_sel, data_inv, derandomize, demux, feher, swap, biphase;
  logic bit_en, bit_stb;
  logic nrz_i, nrz_q, nrz_dly_i, nrz_dly_q;
  logic dec_i, dec_q, sel_i, sel_q;
  logic derand_en, derand_i, derand_q;
  logic symb_clk_q;

  decoder_regs decoder_regs_i (
    .clk(clk), .rs(rs), .en_i(en_i), .wr0_i(wr0_i), .wr1_i(wr1_i),
    .addr_i(addr_i), .din_i(din_i), .dout_o(dout_o), .ctrl_o(ctrl)
  );

  // control fields
  assign fifo_rs_o     = ctrl[FLD_FIFO_RS];
  assign clk_inv_o     = ctrl[FLD_CLK_INV];
  assign clk_sel       = ctrl[FLD_CLK_SEL];
  assign data_inv      = ctrl[FLD_DATA_INV];
  assign derandomize   = ctrl[FLD_DERAND];
  assign demux         = ctrl[FLD_DEMUX];
  assign feher         = ctrl[FLD_FEHER];
  assign swap          = ctrl[FLD_SWAP];
  assign biphase       = ctrl[FLD_BIPHASE];
  assign mode          = ctrl[FLD_MODE_LO +: MODE_WIDTH];
  assign bypass_fifo_o = ctrl[FLD_BYPASS_FIFO];

  // ------------------------------
  // nrz and i/q resync
  // ------------------------------

  biphase_to_nrz biphase_to_nrz_i (
    .clk(clk), .rs(rs), .symb_clk_en_i(symb_clk_en_i), .biphase_i(biphase),
    .symb_i(symb_i_i), .nrz_o(nrz_i), .bit_en_o(bit_en)
  );

  assign bit_stb = symb_clk_en_i & bit_en;

  // q picks up the one bit delay that i sees in biphase_to_nrz
  // plus previous bits of both rails for mark/space
  always_ff @(posedge clk)
  begin
    if (bit_stb)
    begin
      nrz_q     <= symb_q_i;
      nrz_dly_i <= nrz_i;
      nrz_dly_q <= nrz_q;
    end
  end

  mark_space_decoder mark_space_decoder_i (
    .clk(clk), .rs(rs), .clk_en_i(symb_clk_en_i), .bit_en_i(bit_en),
    .mode_i(mode), .din_i(nrz_i), .last_din_i(nrz_dly_i), .dout_o(dec_i)
  );

  mark_space_decoder mark_space_decoder_q (
    .clk(clk), .rs(rs), .clk_en_i(symb_clk_en_i), .bit_en_i(bit_en),
    .mode_i(mode), .din_i(nrz_q), .last_din_i(nrz_dly_q), .dout_o(dec_q)
  );

  iq_demux iq_demux_i (
    .clk(clk), .symb_clk_en_i(symb_clk_en_i), .symb_clk_2x_en_i(symb_clk_2x_en_i),
    .swap_i(swap), .demux_i(demux), .feher_i(feher), .dec_i_i(dec_i),
    .dec_q_i(dec_q), .sel_i_o(sel_i), .sel_q_o(sel_q)
  );

  // ------------------------------
  // derandomize and invert
  // ------------------------------

  // demuxed data arrives at the half-symbol rate
  assign derand_en = demux ? symb_clk_2x_en_i : symb_clk_en_i;

  nrz_derandomizer nrz_derandomizer_i (
    .clk(clk), .rs(rs), .shift_en_i(derand_en), .bypass_n_i(derandomize),
    .din_i(sel_i), .dout_o(derand_i)
  );

  // derandomized bit goes out on both rails
  assign derand_q = derandomize ? derand_i : sel_q;
  assign data_i_o = derand_i ^ data_inv;
  assign data_q_o = derand_q ^ data_inv;

  // ------------------------------
  // output strobes
  // ------------------------------

  assign cout_o = biphase ? bit_en : (clk_sel ? symb_clk_en_i : symb_clk_2x_en_i);

  // square wave at the symbol rate, high from the symbol strobe
  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      symb_clk_q <= 1'b0;
    end
    else if (symb_clk_en_i)
    begin
      symb_clk_q <= 1'b1;
    end
    else if (symb_clk_2x_en_i)
    begin
      symb_clk_q <= ~symb_clk_q;
    end
  end

  assign symb_clk_o = clk_sel ? symb_clk_q : symb_clk_2x_en_i;

endmodule

//--- dv/pcm_decoder_tb.sv
// pcm decoder testbench with strobes, register tasks, data phases, port checks and timeout
`timescale 1ns/1ps

module pcm_decoder_tb
  import pcm_decoder_pkg::*;
();

  localparam int SYMB_CLKS      = 4;
  localparam int SETTLE_SYMB    = 20;
  localparam int PHASE_SYMB     = 60;
  localparam int DATA_PHASES    = 12;
  // three times the data phases covers register traffic and margin
  localparam int TIMEOUT_CYCLES = 3 * DATA_PHASES * PHASE_SYMB * SYMB_CLKS;
  localparam logic [31:0] SEED  = 32'hf15c_7973;

  // symbol patterns
  localparam int PAT_CONST  = 0;
  localparam int PAT_TOGGLE = 1;
  localparam int PAT_CHIPS  = 2;
  localparam int PAT_PRBS   = 3;
  // data check kinds
  localparam int CHK_OFF   = 0;
  localparam int CHK_LEVEL = 1;
  localparam int CHK_ALT   = 2;

  logic                  clk;
  logic                  rs;
  logic                  en_i;
  logic                  wr0_i;
  logic                  wr1_i;
  logic [ADDR_WIDTH-1:0] addr_i;
  logic [BUS_WIDTH-1:0]  din_i;
  logic                  symb_clk_en_i;
  logic                  symb_clk_2x_en_i;
  logic                  symb_i_i;
  logic                  symb_q_i;
  logic [BUS_WIDTH-1:0]  dout_o;
  logic                  data_i_o;
  logic                  data_q_o;
  logic                  cout_o;
  logic                  symb_clk_o;
  logic                  fifo_rs_o;
  logic                  clk_inv_o;
  logic                  bypass_fifo_o;

  logic [1:0]            div_cnt;
  int                    cycle_cnt = 0;
  // expected control register
  logic [CTRL_WIDTH-1:0] ctrl_model;
  // high while the next symbol strobe closes a biphase pair
  logic                  chip_odd;
  // expected symbol clock register
  logic                  symb_clk_exp;
  logic                  have_last;
  logic                  last_q;
  int                    data_mode;
  logic [1:0]            exp_iq;
  string                 test_name;
  logic                  prbs [PHASE_SYMB];
  logic [31:0]           seed_val;

  pcm_decoder pcm_decoder_i (
    .clk(clk), .rs(rs), .en_i(en_i), .wr0_i(wr0_i), .wr1_i(wr1_i), .addr_i(addr_i),
    .din_i(din_i), .symb_clk_en_i(symb_clk_en_i), .symb_clk_2x_en_i(symb_clk_2x_en_i),
    .symb_i_i(symb_i_i), .symb_q_i(symb_q_i), .dout_o(dout_o), .data_i_o(data_i_o),
    .data_q_o(data_q_o), .cout_o(cout_o), .symb_clk_o(symb_clk_o), .fifo_rs_o(fifo_rs_o),
    .clk_inv_o(clk_inv_o), .bypass_fifo_o(bypass_fifo_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------
  // symbol strobes
  // ------------------------------

  // 2x strobe every 2 clk and symbol strobe on every second one
  always @(posedge clk)
  begin
    if (rs)
    begin
      div_cnt          <= 2'd0;
      symb_clk_2x_en_i <= 1'b0;
      symb_clk_en_i    <= 1'b0;
    end
    else
    begin
      div_cnt          <= div_cnt + 2'd1;
      symb_clk_2x_en_i <= div_cnt[0];
      symb_clk_en_i    <= (div_cnt == 2'd3);
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  // ------------------------------
  // helpers
  // ------------------------------

  task automatic expect_val(input string name, input logic [15:0] want, input logic [15:0] got);
    assert (got === want)
    else
    begin
      $display("Fail %s expected %0h actual %0h", name, want, got);
      $display("Test failed");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  function automatic logic [15:0] field_bit(input int pos);
    return 16'(1) << pos;
  endfunction

  function automatic logic [15:0] mode_field(input logic [MODE_WIDTH-1:0] mode);
    return 16'(mode) << FLD_MODE_LO;
  endfunction

  // waits for a symbol boundary so biphase pairs start with the next symbol
  task automatic write_reg(input logic lo, input logic hi, input logic [15:0] data);
    @(posedge clk);
    while (div_cnt != 2'd3)
      @(posedge clk);
    en_i   <= 1'b1;
    wr0_i  <= lo;
    wr1_i  <= hi;
    addr_i <= DEC_CTRL_ADDR;
    din_i  <= data;
    @(posedge clk);
    en_i  <= 1'b0;
    wr0_i <= 1'b0;
    wr1_i <= 1'b0;
    // upper byte lane holds only bits 12:8
    if (lo)
      ctrl_model[7:0] = data[7:0];
    if (hi)
      ctrl_model[12:8] = data[12:8];
  endtask

  task automatic read_reg(input logic [ADDR_WIDTH-1:0] addr);
    logic [15:0] want;
    @(posedge clk);
    en_i   <= 1'b1;
    addr_i <= addr;
    @(negedge clk);
    want = (addr == DEC_CTRL_ADDR) ? {3'b000, ctrl_model} : 16'h0000;
    expect_val("reg_read", want, dout_o);
    @(posedge clk);
    en_i <= 1'b0;
  endtask

  // new symbol goes out together with the symbol strobe
  task automatic send_symbol(input logic i, input logic q);
    @(posedge clk);
    while (div_cnt != 2'd3)
      @(posedge clk);
    symb_i_i <= i;
    symb_q_i <= q;
  endtask

  task automatic run_phase(input string name, input logic [15:0] cfg, input int pattern,
                           input int chk, input logic [1:0] want);
    write_reg(1'b1, 1'b1, cfg);
    test_name = name;
    for (int n = 0; n < PHASE_SYMB; n++)
    begin
      if (n == SETTLE_SYMB)
      begin
        exp_iq    = want;
        data_mode = chk;
      end
      case (pattern)
        PAT_TOGGLE: send_symbol(~n[0], ~n[0]);
        // biphase-l chips 1 then 0 on i with q held high
        PAT_CHIPS:  send_symbol(~n[0], 1'b1);
        PAT_PRBS:   send_symbol(prbs[n], 1'b0);
        default:    send_symbol(1'b1, 1'b0);
      endcase
    end
    data_mode = CHK_OFF;
  endtask

  // ------------------------------
  // port checks
  // ------------------------------

  always @(negedge clk)
  begin
    logic want_cout;
    if (!rs)
    begin
      expect_val("ctrl_out", {ctrl_model[FLD_FIFO_RS], ctrl_model[FLD_CLK_INV],
                 ctrl_model[FLD_BYPASS_FIFO]}, {fifo_rs_o, clk_inv_o, bypass_fifo_o});
      // bit strobe in biphase mode and the clock select pick otherwise
      if (ctrl_model[FLD_BIPHASE])
        want_cout = symb_clk_en_i & chip_odd;
      else
        want_cout = ctrl_model[FLD_CLK_SEL] ? symb_clk_en_i : symb_clk_2x_en_i;
      expect_val("cout", want_cout, cout_o);
      if (ctrl_model[FLD_CLK_SEL])
        expect_val("symb_clk", symb_clk_exp, symb_clk_o);
      else
        expect_val("symb_clk", symb_clk_2x_en_i, symb_clk_o);
      // symbol clock set by the symbol strobe and flipped by the other 2x strobe
      if (symb_clk_en_i)
        symb_clk_exp = 1'b1;
      else if (symb_clk_2x_en_i)
        symb_clk_exp = ~symb_clk_exp;
      if (!ctrl_model[FLD_BIPHASE])
        chip_odd = 1'b0;
      else if (symb_clk_en_i)
        chip_odd = ~chip_odd;
      // steady levels at every output strobe
      if (data_mode == CHK_LEVEL && cout_o)
        expect_val(test_name, exp_iq, {data_i_o, data_q_o});
      // on a single rail q alternates and i is its complement
      if (data_mode == CHK_ALT && symb_clk_2x_en_i)
      begin
        if (have_last)
          expect_val(test_name, {last_q, ~last_q}, {data_i_o, data_q_o});
        have_last = 1'b1;
        last_q    = data_q_o;
      end
      else if (data_mode != CHK_ALT)
        have_last = 1'b0;
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------

  initial
  begin
    seed_val         = $urandom(SEED);
    rs               = 1'b1;
    en_i             = 1'b0;
    wr0_i            = 1'b0;
    wr1_i            = 1'b0;
    addr_i           = '0;
    din_i            = '0;
    symb_clk_en_i    = 1'b0;
    symb_clk_2x_en_i = 1'b0;
    symb_i_i         = 1'b0;
    symb_q_i         = 1'b0;
    ctrl_model       = '0;
    chip_odd         = 1'b0;
    symb_clk_exp     = 1'b0;
    have_last        = 1'b0;
    last_q           = 1'b0;
    data_mode        = CHK_OFF;
    exp_iq           = 2'b00;
    test_name        = "reset";
    repeat (8) @(posedge clk);
    rs <= 1'b0;

    // register bus lanes and address decode
    test_name = "reg_bus";
    read_reg(DEC_CTRL_ADDR);
    write_reg(1'b1, 1'b0, 16'hffff);
    read_reg(DEC_CTRL_ADDR);
    write_reg(1'b0, 1'b1, 16'hffff);
    read_reg(DEC_CTRL_ADDR);
    write_reg(1'b1, 1'b0, 16'h0000);
    read_reg(DEC_CTRL_ADDR);
    read_reg(DEC_CTRL_ADDR ^ 13'h0001);
    read_reg(~DEC_CTRL_ADDR);
    repeat (8)
    begin
      write_reg(1'($urandom), 1'($urandom), 16'($urandom));
      read_reg(DEC_CTRL_ADDR);
    end

    // decode modes
    run_phase("nrzl", 16'h0000, PAT_CONST, CHK_LEVEL, 2'b10);
    run_phase("nrzl_inv", field_bit(FLD_DATA_INV), PAT_CONST, CHK_LEVEL, 2'b01);
    run_phase("nrzl_clk_sel", field_bit(FLD_CLK_SEL), PAT_CONST, CHK_LEVEL, 2'b10);
    run_phase("nrzm_toggle", mode_field(MODE_NRZM), PAT_TOGGLE, CHK_LEVEL, 2'b11);
    run_phase("nrzm_const", mode_field(MODE_NRZM), PAT_CONST, CHK_LEVEL, 2'b00);
    run_phase("nrzs_toggle", mode_field(MODE_NRZS), PAT_TOGGLE, CHK_LEVEL, 2'b00);
    run_phase("nrzs_const", mode_field(MODE_NRZS), PAT_CONST, CHK_LEVEL, 2'b11);
    run_phase("biphase", field_bit(FLD_BIPHASE), PAT_CHIPS, CHK_LEVEL, 2'b11);

    // scrambled stream where each bit is the xor of bits 14 and 15 back
    for (int n = 0; n < PHASE_SYMB; n++)
    begin
      if (n == 0)
        prbs[n] = 1'b1;
      else if (n < DERAND_LEN)
        prbs[n] = 1'($urandom);
      else
        prbs[n] = prbs[n - 14] ^ prbs[n - 15];
    end
    run_phase("derand", field_bit(FLD_DERAND), PAT_PRBS, CHK_LEVEL, 2'b00);

    // demultiplexing onto one rail
    run_phase("demux", field_bit(FLD_DEMUX), PAT_CONST, CHK_ALT, 2'b00);
    run_phase("feher", field_bit(FLD_FEHER), PAT_CONST, CHK_ALT, 2'b00);
    run_phase("feher_swap", field_bit(FLD_FEHER) | field_bit(FLD_SWAP), PAT_CONST,
              CHK_ALT, 2'b00);

    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- filelist.f
rtl/pcm_decoder_pkg.sv
rtl/biphase_to_nrz.sv
rtl/mark_space_decoder.sv
rtl/iq_demux.sv
rtl/nrz_derandomizer.sv
rtl/decoder_regs.sv
rtl/pcm_decoder.sv
dv/pcm_decoder_tb.sv
